/* include/router_macros.svh */
// Sizing constants for the request router.
// Included by the type package and by any RTL that sizes port vectors.

`ifndef ROUTER_MACROS_SVH
`define ROUTER_MACROS_SVH

// port count of the shell
`define N_DESTS_DEF 4

// destination index width, must cover N_DESTS_DEF
`define DEST_BITS   2

// request field widths
`define VADDR_BITS  48
`define LEN_BITS    28
`define TAG_BITS    6

`endif

/* verilog/router_pkg.sv */
// Request and completion types shared by the router RTL and its testbench.
// Refer to the types by scoped name, e.g. router_pkg::req_t.

`include "router_macros.svh"

package router_pkg;

    // request opcode
    typedef enum logic {
        OP_RD = 1'b0,                           // read from destination
        OP_WR = 1'b1                            // write to destination
    } op_e;

    // host request, steered by dest
    typedef struct packed {
        op_e                     op;            // read or write
        logic [`DEST_BITS-1:0]   dest;          // destination port index
        logic [`VADDR_BITS-1:0]  vaddr;         // virtual address
        logic [`LEN_BITS-1:0]    len;           // transfer length in bytes
        logic [`TAG_BITS-1:0]    tag;           // host tag, echoed on completion
        logic                    last;          // last request of a batch
    } req_t;

    // completion back to the host
    typedef struct packed {
        logic [`TAG_BITS-1:0]    tag;           // tag of the finished request
        logic                    err;           // destination reported an error
        logic [`DEST_BITS-1:0]   src;           // port the completion came from
    } cmpl_t;

endpackage

/* verilog/meta_reg.sv */
// Two-entry skid slice for a valid/ready stream.
// Registers both the data path and the ready path so no combinational
// path crosses it. One cycle of latency, full throughput.

`timescale 1ns / 1ps

module meta_reg #(
    parameter type PAYLOAD_T = logic [7:0]
) (
    input  logic     aclk,
    input  logic     rst,

    input  logic     s_valid,
    output logic     s_ready,
    input  PAYLOAD_T s_data,

    output logic     m_valid,
    input  logic     m_ready,
    output PAYLOAD_T m_data
);

logic     skid_valid;                            // second entry occupied
PAYLOAD_T skid_data;                             // second entry payload
logic     load_out;                              // output entry may take a new item
logic     in_fire;                               // upstream transfer this cycle
logic     load_skid;                             // park input in the skid entry

// ready only drops once both entries hold data
assign s_ready   = !skid_valid;

assign in_fire   = s_valid && s_ready;
assign load_out  = m_ready || !m_valid;          // output empty or draining
assign load_skid = in_fire && !load_out;         // output stalled, catch the item

// control
always_ff @(posedge aclk) begin
    if (rst) begin
        m_valid    <= 1'b0;
        skid_valid <= 1'b0;
    end else begin
        if (load_out) begin
            m_valid    <= skid_valid || in_fire; // skid first, else fresh input
            skid_valid <= 1'b0;                  // skid always drains into output
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end
end

// payload, no reset needed
always_ff @(posedge aclk) begin
    if (load_out) begin
        m_data <= skid_valid ? skid_data : s_data; // keep order, older item wins
    end
    if (load_skid) begin
        skid_data <= s_data;
    end
end

endmodule

/* verilog/dest_req_mux.sv */
// Steers one host request stream to N_DESTS destination ports.
// The dest field picks the port; each port has its own registered slice,
// so a stalled port only blocks the input while the head request targets it.

`timescale 1ns / 1ps

`include "router_macros.svh"

module dest_req_mux #(
    parameter int N_DESTS = `N_DESTS_DEF
) (
    input  logic                                aclk,
    input  logic                                rst,

    // host side
    input  logic                                s_req_valid,
    output logic                                s_req_ready,
    input  router_pkg::req_t                    s_req_data,

    // destination side, indexed by port
    output logic             [N_DESTS-1:0]      m_req_valid,
    input  logic             [N_DESTS-1:0]      m_req_ready,
    output router_pkg::req_t [N_DESTS-1:0]      m_req_data
);

logic [N_DESTS-1:0] slc_valid;                   // one-hot valid into the slices
logic [N_DESTS-1:0] slc_ready;                   // slice readies

// decode dest into a one-hot valid
always_comb begin
    for (int i = 0; i < N_DESTS; i++) begin
        slc_valid[i] = s_req_valid && (s_req_data.dest == `DEST_BITS'(i));
    end
end

// only the addressed slice throttles the host
assign s_req_ready = slc_ready[s_req_data.dest];

// one slice per port, data broadcast to all of them
for (genvar i = 0; i < N_DESTS; i++) begin : g_port
    meta_reg #(
        .PAYLOAD_T (router_pkg::req_t)
    ) inst_reg (
        .aclk    (aclk),
        .rst     (rst),
        .s_valid (slc_valid[i]),
        .s_ready (slc_ready[i]),
        .s_data  (s_req_data),           // same request seen by every slice
        .m_valid (m_req_valid[i]),
        .m_ready (m_req_ready[i]),
        .m_data  (m_req_data[i])
    );
end

endmodule

/* verilog/cmpl_arb.sv */
// Merges N_DESTS completion streams into one host completion stream.
// Round-robin grant, one input per cycle, starting at a rotating pointer.
// The granted completion is tagged with its port index and registered
// through an output slice.

`timescale 1ns / 1ps

`include "router_macros.svh"

module cmpl_arb #(
    parameter int N_DESTS = `N_DESTS_DEF
) (
    input  logic                                aclk,
    input  logic                                rst,

    // destination side, indexed by port
    input  logic              [N_DESTS-1:0]     s_cmpl_valid,
    output logic              [N_DESTS-1:0]     s_cmpl_ready,
    input  router_pkg::cmpl_t [N_DESTS-1:0]     s_cmpl_data,

    // host side
    output logic                                m_cmpl_valid,
    input  logic                                m_cmpl_ready,
    output router_pkg::cmpl_t                   m_cmpl_data
);

localparam int IDX_BITS = `DEST_BITS;            // index width matching cmpl_t.src

logic [IDX_BITS-1:0] rr_ptr;                     // highest priority port this cycle
logic [IDX_BITS-1:0] gnt_idx;                    // chosen port
logic                gnt_found;                  // some input is valid
logic                gnt_fire;                   // chosen input transfers now
logic                slc_ready;                  // output slice has room
router_pkg::cmpl_t   gnt_data;                   // chosen completion with src rewritten

// first valid input at or after the pointer
always_comb begin
    gnt_found = 1'b0;
    gnt_idx   = '0;
    for (int k = 0; k < N_DESTS; k++) begin
        if (!gnt_found && s_cmpl_valid[(int'(rr_ptr) + k) % N_DESTS]) begin
            gnt_found = 1'b1;
            gnt_idx   = IDX_BITS'((int'(rr_ptr) + k) % N_DESTS);
        end
    end
end

// no grant while the output slice is full
assign gnt_fire = gnt_found && slc_ready;

// ready goes to the winner only
for (genvar i = 0; i < N_DESTS; i++) begin : g_rdy
    assign s_cmpl_ready[i] = gnt_fire && (gnt_idx == IDX_BITS'(i));
end

// tag with the source port
always_comb begin
    gnt_data     = s_cmpl_data[gnt_idx];
    gnt_data.src = gnt_idx;
end

// pointer moves past the winner on every transfer
always_ff @(posedge aclk) begin
    if (rst) begin
        rr_ptr <= '0;
    end else if (gnt_fire) begin
        rr_ptr <= (int'(gnt_idx) == N_DESTS - 1) ? '0 : gnt_idx + IDX_BITS'(1); // wrap
    end
end

// output slice
meta_reg #(
    .PAYLOAD_T (router_pkg::cmpl_t)
) inst_reg (
    .aclk    (aclk),
    .rst     (rst),
    .s_valid (gnt_fire),
    .s_ready (slc_ready),
    .s_data  (gnt_data),
    .m_valid (m_cmpl_valid),
    .m_ready (m_cmpl_ready),
    .m_data  (m_cmpl_data)
);

endmodule

/* verilog/req_router_top.sv */
// Top level of the request router.
// Requests fan out from the host to N_DESTS ports by dest; completions from
// the ports merge back into one host stream. Instances and wiring only.

`timescale 1ns / 1ps

`include "router_macros.svh"

module req_router_top (
    input  logic                                    aclk,
    input  logic                                    rst,

    // host requests in
    input  logic                                    s_req_valid,
    output logic                                    s_req_ready,
    input  router_pkg::req_t                        s_req_data,

    // requests out to the destinations
    output logic              [`N_DESTS_DEF-1:0]    m_req_valid,
    input  logic              [`N_DESTS_DEF-1:0]    m_req_ready,
    output router_pkg::req_t  [`N_DESTS_DEF-1:0]    m_req_data,

    // completions in from the destinations
    input  logic              [`N_DESTS_DEF-1:0]    s_cmpl_valid,
    output logic              [`N_DESTS_DEF-1:0]    s_cmpl_ready,
    input  router_pkg::cmpl_t [`N_DESTS_DEF-1:0]    s_cmpl_data,

    // merged completions to the host
    output logic                                    m_cmpl_valid,
    input  logic                                    m_cmpl_ready,
    output router_pkg::cmpl_t                       m_cmpl_data
);

// request fan-out
dest_req_mux #(
    .N_DESTS (`N_DESTS_DEF)
) inst_mux (
    .aclk        (aclk),
    .rst         (rst),
    .s_req_valid (s_req_valid),
    .s_req_ready (s_req_ready),
    .s_req_data  (s_req_data),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready),
    .m_req_data  (m_req_data)
);

// completion merge
cmpl_arb #(
    .N_DESTS (`N_DESTS_DEF)
) inst_arb (
    .aclk         (aclk),
    .rst          (rst),
    .s_cmpl_valid (s_cmpl_valid),
    .s_cmpl_ready (s_cmpl_ready),
    .s_cmpl_data  (s_cmpl_data),
    .m_cmpl_valid (m_cmpl_valid),
    .m_cmpl_ready (m_cmpl_ready),
    .m_cmpl_data  (m_cmpl_data)
);

endmodule

/* bench/req_router_sva.sv */
// Protocol, routing and arbitration assertions for the request router.
// Bound onto req_router_top from the testbench. fail_cnt holds the number
// of failed assertions and is read by the testbench at the end of the run.

`timescale 1ns / 1ps

`include "router_macros.svh"

module req_router_sva (
    input logic                                    aclk,
    input logic                                    rst,
    input logic                                    s_req_valid,
    input logic                                    s_req_ready,
    input router_pkg::req_t                        s_req_data,
    input logic              [`N_DESTS_DEF-1:0]    m_req_valid,
    input logic              [`N_DESTS_DEF-1:0]    m_req_ready,
    input router_pkg::req_t  [`N_DESTS_DEF-1:0]    m_req_data,
    input logic              [`N_DESTS_DEF-1:0]    s_cmpl_valid,
    input logic              [`N_DESTS_DEF-1:0]    s_cmpl_ready,
    input router_pkg::cmpl_t [`N_DESTS_DEF-1:0]    s_cmpl_data,
    input logic                                    m_cmpl_valid,
    input logic                                    m_cmpl_ready,
    input router_pkg::cmpl_t                       m_cmpl_data
);

localparam int N = `N_DESTS_DEF;

int fail_cnt = 0;                                // failed assertions so far

// all outputs idle in the first cycle out of reset
a_reset: assert property (@(posedge aclk)
    $fell(rst) |-> (m_req_valid == '0 && !m_cmpl_valid && s_req_ready))
    else begin
        fail_cnt++;
        $error("CHECK FAILED at %0t: outputs not idle after reset", $time);
    end

for (genvar i = 0; i < N; i++) begin : g_port
    // a port only ever carries requests addressed to it
    a_dest: assert property (@(posedge aclk) disable iff (rst)
        m_req_valid[i] |-> m_req_data[i].dest == `DEST_BITS'(i))
        else begin
            fail_cnt++;
            $error("CHECK FAILED at %0t: port %0d carries wrong dest", $time, i);
        end

    // empty port shows the accepted request one cycle later, unchanged
    a_route: assert property (@(posedge aclk) disable iff (rst)
        (s_req_valid && s_req_ready && s_req_data.dest == `DEST_BITS'(i) && !m_req_valid[i])
        |=> (m_req_valid[i] && m_req_data[i] == $past(s_req_data)))
        else begin
            fail_cnt++;
            $error("CHECK FAILED at %0t: request lost or changed on port %0d", $time, i);
        end

    // stalled request holds valid and data
    a_req_hold: assert property (@(posedge aclk) disable iff (rst)
        (m_req_valid[i] && !m_req_ready[i]) |=> (m_req_valid[i] && $stable(m_req_data[i])))
        else begin
            fail_cnt++;
            $error("CHECK FAILED at %0t: port %0d dropped a stalled request", $time, i);
        end

    // an empty port never throttles the host, whatever the other ports do
    a_hol: assert property (@(posedge aclk) disable iff (rst)
        (s_req_valid && s_req_data.dest == `DEST_BITS'(i) && !m_req_valid[i]) |-> s_req_ready)
        else begin
            fail_cnt++;
            $error("CHECK FAILED at %0t: host blocked for empty port %0d", $time, i);
        end

    // granted completion shows up next cycle, tagged with its port
    a_tag: assert property (@(posedge aclk) disable iff (rst)
        (s_cmpl_valid[i] && s_cmpl_ready[i] && (!m_cmpl_valid || m_cmpl_ready))
        |=> (m_cmpl_valid && m_cmpl_data.src == `DEST_BITS'(i)
             && m_cmpl_data.tag == $past(s_cmpl_data[i].tag)
             && m_cmpl_data.err == $past(s_cmpl_data[i].err)))
        else begin
            fail_cnt++;
            $error("CHECK FAILED at %0t: completion from port %0d mistagged", $time, i);
        end

    // ready only towards a port that has something to give
    a_gnt: assert property (@(posedge aclk) disable iff (rst)
        s_cmpl_ready[i] |-> s_cmpl_valid[i])
        else begin
            fail_cnt++;
            $error("CHECK FAILED at %0t: grant to idle port %0d", $time, i);
        end
end

// at most one winner per cycle
a_onehot: assert property (@(posedge aclk) disable iff (rst)
    $onehot0(s_cmpl_ready))
    else begin
        fail_cnt++;
        $error("CHECK FAILED at %0t: more than one completion granted", $time);
    end

// a fresh completion needs a grant in the cycle before
a_new: assert property (@(posedge aclk) disable iff (rst)
    (m_cmpl_valid && !$past(m_cmpl_valid)) |-> $past(|(s_cmpl_valid & s_cmpl_ready)))
    else begin
        fail_cnt++;
        $error("CHECK FAILED at %0t: completion appeared without a grant", $time);
    end

// stalled completion holds valid and data
a_cmpl_hold: assert property (@(posedge aclk) disable iff (rst)
    (m_cmpl_valid && !m_cmpl_ready) |=> (m_cmpl_valid && $stable(m_cmpl_data)))
    else begin
        fail_cnt++;
        $error("CHECK FAILED at %0t: stalled completion changed", $time);
    end

// all ports busy and host ready, src steps by one modulo the port count
a_fair: assert property (@(posedge aclk) disable iff (rst)
    (m_cmpl_valid && m_cmpl_ready && s_cmpl_valid == '1 && s_cmpl_ready != '0)
    |=> (m_cmpl_valid
         && m_cmpl_data.src == `DEST_BITS'((int'($past(m_cmpl_data.src)) + 1) % N)))
    else begin
        fail_cnt++;
        $error("CHECK FAILED at %0t: round-robin order broken", $time);
    end

endmodule

/* bench/req_router_tb.sv */
// Testbench for the request router top level.
// Walks through reset, routing, back-pressure, head-of-line and completion
// phases; the bound assertion module does all value checking.

`timescale 1ns / 1ps

`include "router_macros.svh"

module req_router_tb;

localparam int N       = `N_DESTS_DEF;
localparam int TIMEOUT = 2000;                   // cycles allowed per wait loop

logic                        aclk         = 1'b0;
logic                        rst          = 1'b1;
logic                        s_req_valid  = 1'b0;
logic                        s_req_ready;
router_pkg::req_t            s_req_data   = '0;
logic [N-1:0]                m_req_valid;
logic [N-1:0]                m_req_ready  = '0;
router_pkg::req_t [N-1:0]    m_req_data;
logic [N-1:0]                s_cmpl_valid = '0;
logic [N-1:0]                s_cmpl_ready;
router_pkg::cmpl_t [N-1:0]   s_cmpl_data  = '0;
logic                        m_cmpl_valid;
logic                        m_cmpl_ready = 1'b0;
router_pkg::cmpl_t           m_cmpl_data;

integer      seed       = 32'ha16f_3167;
logic [31:0] snk_rnd;                            // sink side random word
logic [31:0] src_rnd;                            // completion source random word

logic         req_rand    = 1'b0;                // random destination ready
logic [N-1:0] stall_mask  = '0;                  // ports held not ready
logic         host_rand   = 1'b0;                // random host completion ready
logic         cmpl_all    = 1'b0;                // sources never idle while work is left
int           cmpl_target = 0;                   // completions per port to issue
int           cmpl_issued [N];                   // completions issued per port
int           cmpl_seen   = 0;                   // completions taken by the host
logic [N-1:0] cmpl_take   = '0;                  // source transfers at the next edge
int           phase_cnt   = 0;
int           timeout_cnt = 0;
string        phase_name  = "reset";

always #2 aclk = ~aclk;                          // 4 ns period

bind req_router_top req_router_sva u_sva (
    .aclk         (aclk),
    .rst          (rst),
    .s_req_valid  (s_req_valid),
    .s_req_ready  (s_req_ready),
    .s_req_data   (s_req_data),
    .m_req_valid  (m_req_valid),
    .m_req_ready  (m_req_ready),
    .m_req_data   (m_req_data),
    .s_cmpl_valid (s_cmpl_valid),
    .s_cmpl_ready (s_cmpl_ready),
    .s_cmpl_data  (s_cmpl_data),
    .m_cmpl_valid (m_cmpl_valid),
    .m_cmpl_ready (m_cmpl_ready),
    .m_cmpl_data  (m_cmpl_data)
);

req_router_top i_dut (
    .aclk         (aclk),
    .rst          (rst),
    .s_req_valid  (s_req_valid),
    .s_req_ready  (s_req_ready),
    .s_req_data   (s_req_data),
    .m_req_valid  (m_req_valid),
    .m_req_ready  (m_req_ready),
    .m_req_data   (m_req_data),
    .s_cmpl_valid (s_cmpl_valid),
    .s_cmpl_ready (s_cmpl_ready),
    .s_cmpl_data  (s_cmpl_data),
    .m_cmpl_valid (m_cmpl_valid),
    .m_cmpl_ready (m_cmpl_ready),
    .m_cmpl_data  (m_cmpl_data)
);

// destination and host sinks
always @(posedge aclk) begin
    snk_rnd = $random(seed);
    if (rst) begin
        m_req_ready  <= '0;
        m_cmpl_ready <= 1'b0;
    end else begin
        m_req_ready  <= (req_rand ? snk_rnd[N-1:0] : '1) & ~stall_mask;
        m_cmpl_ready <= host_rand ? snk_rnd[8] : 1'b1;
    end
end

// handshakes sampled mid-cycle complete at the next rising edge
always @(negedge aclk) begin
    cmpl_take <= s_cmpl_valid & s_cmpl_ready;
    if (m_cmpl_valid && m_cmpl_ready) begin
        cmpl_seen <= cmpl_seen + 1;
    end
end

// completion sources that each hold an item until it is taken
always @(posedge aclk) begin
    if (rst) begin
        s_cmpl_valid <= '0;
        for (int i = 0; i < N; i++) begin
            cmpl_issued[i] = 0;
        end
    end else begin
        for (int i = 0; i < N; i++) begin
            if (!s_cmpl_valid[i] || cmpl_take[i]) begin
                src_rnd = $random(seed);
                if (cmpl_issued[i] < cmpl_target && (cmpl_all || src_rnd[0])) begin
                    s_cmpl_valid[i]     <= 1'b1;
                    s_cmpl_data[i].tag  <= src_rnd[8 +: `TAG_BITS];
                    s_cmpl_data[i].err  <= src_rnd[16];
                    s_cmpl_data[i].src  <= src_rnd[20 +: `DEST_BITS]; // arbiter overwrites
                    cmpl_issued[i]      = cmpl_issued[i] + 1;
                end else begin
                    s_cmpl_valid[i] <= 1'b0;
                end
            end
        end
    end
end

function automatic logic [`DEST_BITS-1:0] pick_port();
    logic [31:0] r;
    r = $random(seed);
    return `DEST_BITS'(r % N);
endfunction

// any port but the stalled one
function automatic logic [`DEST_BITS-1:0] pick_other(input logic [`DEST_BITS-1:0] busy_port);
    logic [31:0] r;
    r = $random(seed);
    return `DEST_BITS'((int'(busy_port) + 1 + int'(r % (N - 1))) % N);
endfunction

function automatic router_pkg::req_t make_req(input logic [`DEST_BITS-1:0] dest);
    router_pkg::req_t req;
    logic [95:0]      bits;
    bits      = {$random(seed), $random(seed), $random(seed)};
    req.op    = bits[0] ? router_pkg::OP_WR : router_pkg::OP_RD;
    req.dest  = dest;
    req.vaddr = bits[95 -: `VADDR_BITS];
    req.len   = bits[47 -: `LEN_BITS];
    req.tag   = bits[19 -: `TAG_BITS];
    req.last  = bits[1];
    return req;
endfunction

task automatic report_timeout(input string what);
    $display("timeout in phase %s: %s", phase_name, what);
    timeout_cnt++;
endtask

task automatic end_phase();
    phase_cnt++;
    $display("phase %0d %s done at %0t ns", phase_cnt, phase_name, $time);
endtask

// starts on a rising edge and returns on the edge where the request transferred
task automatic send_req(input router_pkg::req_t req);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    s_req_valid <= 1'b1;
    s_req_data  <= req;
    while (!done && waited < TIMEOUT) begin
        @(negedge aclk);
        done = s_req_ready;
        waited++;
        @(posedge aclk);
    end
    s_req_valid <= 1'b0;
    if (!done) begin
        report_timeout("request was never accepted");
    end
endtask

task automatic wait_req_ready();
    int   waited;
    logic ready;
    waited = 0;
    ready  = 1'b0;
    while (!ready && waited < TIMEOUT) begin
        @(negedge aclk);
        ready = s_req_ready;
        waited++;
    end
    @(posedge aclk);
    if (!ready) begin
        report_timeout("router never became ready");
    end
endtask

task automatic drain_req();
    int   waited;
    logic busy;
    waited = 0;
    busy   = 1'b1;
    while (busy && waited < TIMEOUT) begin
        @(negedge aclk);
        busy = (m_req_valid != '0);
        waited++;
    end
    @(posedge aclk);
    if (busy) begin
        report_timeout("request ports did not drain");
    end
endtask

task automatic wait_cmpl(input int total);
    int   waited;
    logic pending;
    waited  = 0;
    pending = 1'b1;
    while (pending && waited < TIMEOUT) begin
        @(negedge aclk);
        pending = (cmpl_seen < total);
        waited++;
    end
    @(posedge aclk);
    if (pending) begin
        report_timeout("completions did not all arrive");
    end
endtask

initial begin
    logic [`DEST_BITS-1:0] port;
    repeat (3) @(posedge aclk);
    rst <= 1'b0;

    phase_name = "reset";
    wait_req_ready();
    end_phase();

    phase_name = "routing";                      // all ports ready
    for (int n = 0; n < 32; n++) begin
        send_req(make_req(pick_port()));
    end
    drain_req();
    end_phase();

    phase_name = "backpressure";                 // bursts into random ready
    req_rand <= 1'b1;
    for (int b = 0; b < 12; b++) begin
        port = pick_port();
        repeat (4) send_req(make_req(port));
    end
    drain_req();
    req_rand <= 1'b0;
    end_phase();

    phase_name = "head_of_line";                 // fill one port and feed the rest
    port = pick_port();
    stall_mask <= `N_DESTS_DEF'(1) << port;
    repeat (2) send_req(make_req(port));
    for (int n = 0; n < 12; n++) begin
        send_req(make_req(pick_other(port)));
    end
    stall_mask <= '0;
    drain_req();
    end_phase();

    phase_name = "cmpl_random";
    host_rand   <= 1'b1;
    cmpl_all    <= 1'b0;
    cmpl_target <= 8;
    wait_cmpl(N * 8);
    end_phase();

    phase_name = "cmpl_fair";                    // every port busy and host always ready
    host_rand   <= 1'b0;
    cmpl_all    <= 1'b1;
    cmpl_target <= 16;
    wait_cmpl(N * 16);
    end_phase();

    $display("phases %0d, timeouts %0d, assertion failures %0d",
             phase_cnt, timeout_cnt, i_dut.u_sva.fail_cnt);
    if (timeout_cnt == 0 && i_dut.u_sva.fail_cnt == 0) begin
        $display("sim passed");
    end else begin
        $display("sim failed");
    end
    $finish;
end

endmodule

/* flist.f */
+incdir+include
verilog/router_pkg.sv
verilog/meta_reg.sv
verilog/dest_req_mux.sv
verilog/cmpl_arb.sv
verilog/req_router_top.sv
bench/req_router_sva.sv
bench/req_router_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the request router testbench with Verilator, runs it, and decides
# pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module req_router_tb \
    -f flist.f -o req_router_sim \
    && ./obj_dir/req_router_sim +verilator+error+limit+100 | tee sim.log \
    || { echo "build or run error"; exit 1; }

grep -qx "sim passed" sim.log \
    && echo "result: pass" \
    || { echo "result: fail"; exit 1; }
